// ==== common/sonic_board_pkg.sv ====
`default_nettype none

package sonic_board_pkg;

  // management and link status widths
  localparam int MGMT_W  = 32;
  localparam int LTSSM_W = 5;
  localparam int LANE_W  = 4;
  localparam int LINK_W  = LANE_W + LTSSM_W;

  // ltssm codes seen on the hard ip test bus
  localparam logic [LTSSM_W-1:0] LTSSM_COMPLIANCE = 5'd3;  // polling.compliance
  localparam logic [LTSSM_W-1:0] LTSSM_L0         = 5'd15;

  // control word, one bit per cage in each field
  localparam int PHY_RST_BIT  = 0;  // read-only
  localparam int RATE_SEL_LSB = 1;

  function automatic int tx_dis_lsb(input int num_sfp);
    return RATE_SEL_LSB + num_sfp;
  endfunction

  function automatic int prwdn_lsb(input int num_sfp);
    return RATE_SEL_LSB + 2 * num_sfp;
  endfunction

  // status word 0 adds the cage pins above the control mirror
  function automatic int tx_fault_lsb(input int num_sfp);
    return RATE_SEL_LSB + 3 * num_sfp;
  endfunction

  function automatic int mod_abs_lsb(input int num_sfp);
    return RATE_SEL_LSB + 4 * num_sfp;
  endfunction

  function automatic int stat_used_w(input int num_sfp);
    return mod_abs_lsb(num_sfp) + num_sfp;  // bits above this read zero
  endfunction

  // link status word, raw for read-back and split for the leds
  typedef union packed {
    logic [LINK_W-1:0] raw;
    struct packed {
      logic [LANE_W-1:0]  lane_active;
      logic [LTSSM_W-1:0] ltssm;
    } fields;
  } link_status_u;

endpackage

`default_nettype wire

// ==== design/link_led.sv ====
`timescale 1ns/1ns
`default_nettype none

module link_led
  import sonic_board_pkg::*;
#(
  parameter int ALIVE_CNT_W = 26
) (
  input  wire               clk_out_buf,
  input  wire               any_rstn_rr,
  input  wire  [LINK_W-1:0] link_status,
  input  wire               gen2_speed,
  output logic              alive_led,
  output logic              comp_led,
  output logic              l0_led,
  output logic              gen2_led,
  output logic [LANE_W-1:0] lane_active_led,
  output logic [LINK_W-1:0] link_word
);

  link_status_u           ls;
  logic [ALIVE_CNT_W-1:0] alive_cnt;

  assign ls = link_status;

  // free running blinker, top bit toggles every 2^(W-1) cycles
  always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
  begin
    if (!any_rstn_rr)
    begin
      alive_cnt <= '0;
      alive_led <= 1'b0;
    end
    else
    begin
      alive_cnt <= alive_cnt + 1'b1;
      alive_led <= alive_cnt[ALIVE_CNT_W-1];
    end
  end

  // ltssm decode and lane leds
  always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
  begin
    if (!any_rstn_rr)
    begin
      comp_led        <= 1'b0;
      l0_led          <= 1'b0;
      lane_active_led <= '0;
      gen2_led        <= 1'b0;
      link_word       <= '0;
    end
    else
    begin
      comp_led        <= (ls.fields.ltssm == LTSSM_COMPLIANCE);
      l0_led          <= (ls.fields.ltssm == LTSSM_L0);
      lane_active_led <= ls.fields.lane_active;
      gen2_led        <= gen2_speed;
      link_word       <= ls.raw;  // goes to read-back word 1
    end
  end

  // compliance and L0 are exclusive link states
  a_led_exclusive: assert property (@(posedge clk_out_buf) disable iff (!any_rstn_rr)
    !(comp_led && l0_led));

endmodule

`default_nettype wire

// ==== sfp_ctrl/mgmt_write_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mgmt_write_decode
  import sonic_board_pkg::*;
#(
  parameter int NUM_SFP = 2
) (
  input  wire                clk_out_buf,
  input  wire                any_rstn_rr,
  input  wire                mgmt_write,
  input  wire  [MGMT_W-1:0]  mgmt_wdata,
  output logic [NUM_SFP-1:0] cage_wr,
  output logic [NUM_SFP-1:0] rate_sel_in,
  output logic [NUM_SFP-1:0] tx_disable_in,
  output logic [NUM_SFP-1:0] prwdn_in
);

  logic wr_q;

  // strobe stage
  always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
  begin
    if (!any_rstn_rr)
      wr_q <= 1'b0;
    else
      wr_q <= mgmt_write;
  end

  // field capture, index i of each field is cage i
  // bit 0 (phy reset) and bits above the layout are dropped
  always_ff @(posedge clk_out_buf)
  begin
    if (mgmt_write)
    begin
      rate_sel_in   <= mgmt_wdata[RATE_SEL_LSB +: NUM_SFP];
      tx_disable_in <= mgmt_wdata[tx_dis_lsb(NUM_SFP) +: NUM_SFP];
      prwdn_in      <= mgmt_wdata[prwdn_lsb(NUM_SFP) +: NUM_SFP];
    end
  end

  assign cage_wr = {NUM_SFP{wr_q}};  // all cages load together

  // an X strobe would corrupt every cage register at once
  a_write_known: assert property (@(posedge clk_out_buf) disable iff (!any_rstn_rr)
    !$isunknown(mgmt_write));

endmodule

`default_nettype wire

// ==== sfp_ctrl/sfp_cage.sv ====
`timescale 1ns/1ns
`default_nettype none

module sfp_cage (
  input  wire  clk_out_buf,
  input  wire  any_rstn_rr,
  input  wire  cage_wr,
  input  wire  rate_sel_in,
  input  wire  tx_disable_in,
  input  wire  prwdn_in,
  input  wire  tx_fault,     // async from the cage
  input  wire  mod_abs,      // async, high when no module
  output logic rate_sel,     // high for > 4.25 GBd
  output logic tx_disable,
  output logic lane_prwdn,
  output logic tx_fault_sync,
  output logic mod_abs_sync
);

  logic tx_fault_meta;
  logic mod_abs_meta;

  // cage control register
  always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
  begin
    if (!any_rstn_rr)
    begin
      rate_sel   <= 1'b0;
      tx_disable <= 1'b0;
      lane_prwdn <= 1'b0;
    end
    else if (cage_wr)
    begin
      rate_sel   <= rate_sel_in;
      tx_disable <= tx_disable_in;
      lane_prwdn <= prwdn_in;
    end
  end

  // two flop synchronizers for the cage pins
  always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
  begin
    if (!any_rstn_rr)
    begin
      tx_fault_meta <= 1'b0;
      mod_abs_meta  <= 1'b0;
      tx_fault_sync <= 1'b0;
      mod_abs_sync  <= 1'b0;
    end
    else
    begin
      tx_fault_meta <= tx_fault;
      mod_abs_meta  <= mod_abs;
      tx_fault_sync <= tx_fault_meta;
      mod_abs_sync  <= mod_abs_meta;
    end
  end

endmodule

`default_nettype wire

// ==== sfp_ctrl/status_word_assemble.sv ====
`timescale 1ns/1ns
`default_nettype none

module status_word_assemble
  import sonic_board_pkg::*;
#(
  parameter int NUM_SFP = 2
) (
  input  wire                clk_out_buf,
  input  wire                any_rstn_rr,
  input  wire                phy_reset_n,
  input  wire  [NUM_SFP-1:0] rate_sel,
  input  wire  [NUM_SFP-1:0] tx_disable,
  input  wire  [NUM_SFP-1:0] lane_prwdn,
  input  wire  [NUM_SFP-1:0] tx_fault_sync,
  input  wire  [NUM_SFP-1:0] mod_abs_sync,
  input  wire  [LINK_W-1:0]  link_word,
  output logic [MGMT_W-1:0]  mgmt_rdata_0,
  output logic [MGMT_W-1:0]  mgmt_rdata_1
);

  link_status_u      lw;
  logic [MGMT_W-1:0] word0_d;
  logic [MGMT_W-1:0] word1_d;

  assign lw = link_word;

  // word 0 mirrors the control layout, then the cage pins
  always_comb
  begin
    word0_d = '0;
    word0_d[PHY_RST_BIT]                           = phy_reset_n;
    word0_d[RATE_SEL_LSB +: NUM_SFP]               = rate_sel;
    word0_d[tx_dis_lsb(NUM_SFP) +: NUM_SFP]        = tx_disable;
    word0_d[prwdn_lsb(NUM_SFP) +: NUM_SFP]         = lane_prwdn;
    word0_d[tx_fault_lsb(NUM_SFP) +: NUM_SFP]      = tx_fault_sync;
    word0_d[mod_abs_lsb(NUM_SFP) +: NUM_SFP]       = mod_abs_sync;
  end

  always_comb
  begin
    word1_d             = '0;
    word1_d[LINK_W-1:0] = lw.raw;  // ltssm low, lanes above
  end

  always_ff @(posedge clk_out_buf or negedge any_rstn_rr)
  begin
    if (!any_rstn_rr)
    begin
      mgmt_rdata_0 <= '0;
      mgmt_rdata_1 <= '0;
    end
    else
    begin
      mgmt_rdata_0 <= word0_d;
      mgmt_rdata_1 <= word1_d;
    end
  end

  // software reads these bits as reserved zero
  a_upper_zero: assert property (@(posedge clk_out_buf) disable iff (!any_rstn_rr)
    ((mgmt_rdata_0 >> stat_used_w(NUM_SFP)) == '0) && ((mgmt_rdata_1 >> LINK_W) == '0));

endmodule

`default_nettype wire

// ==== design/sonic_board_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module sonic_board_ctrl
  import sonic_board_pkg::*;
#(
  parameter int NUM_SFP     = 2,
  parameter int ALIVE_CNT_W = 26
) (
  input  wire                clk_out_buf,
  input  wire                pcie_rstn,
  input  wire                local_rstn_ext,
  input  wire                gen2_speed,
  input  wire  [LINK_W-1:0]  link_status,
  input  wire  [NUM_SFP-1:0] sfp_tx_fault,
  input  wire  [NUM_SFP-1:0] sfp_mod_abs,
  input  wire                mgmt_write,
  input  wire  [MGMT_W-1:0]  mgmt_wdata,
  output logic               phy_reset_n,
  output logic               alive_led,
  output logic               comp_led,
  output logic               l0_led,
  output logic               gen2_led,
  output logic [LANE_W-1:0]  lane_active_led,
  output logic [NUM_SFP-1:0] sfp_rate_sel,
  output logic [NUM_SFP-1:0] sfp_tx_disable,
  output logic [NUM_SFP-1:0] lane_prwdn,
  output logic [MGMT_W-1:0]  mgmt_rdata_0,
  output logic [MGMT_W-1:0]  mgmt_rdata_1
);

  logic               any_rstn;
  logic               any_rstn_r;
  logic               any_rstn_rr;
  logic [NUM_SFP-1:0] cage_wr;
  logic [NUM_SFP-1:0] rate_sel_in;
  logic [NUM_SFP-1:0] tx_disable_in;
  logic [NUM_SFP-1:0] prwdn_in;
  logic [NUM_SFP-1:0] tx_fault_sync;
  logic [NUM_SFP-1:0] mod_abs_sync;
  logic [LINK_W-1:0]  link_word;

  // the whole status layout has to fit one management word
  if (NUM_SFP < 1 || stat_used_w(NUM_SFP) > MGMT_W)
  begin : g_bad_num_sfp
    $error("NUM_SFP does not fit the status word layout");
  end

  assign phy_reset_n = local_rstn_ext;  // straight to the phy pin
  assign any_rstn    = pcie_rstn & local_rstn_ext;

  // reset synchronizer, async assert and two edge release
  always_ff @(posedge clk_out_buf or negedge any_rstn)
  begin
    if (!any_rstn)
    begin
      any_rstn_r  <= 1'b0;
      any_rstn_rr <= 1'b0;
    end
    else
    begin
      any_rstn_r  <= 1'b1;
      any_rstn_rr <= any_rstn_r;
    end
  end

  a_rst_held: assert property (@(posedge clk_out_buf)
    !(pcie_rstn && local_rstn_ext) |-> !any_rstn_rr);

  link_led #(
    .ALIVE_CNT_W (ALIVE_CNT_W)
  ) u_link_led (
    .clk_out_buf     (clk_out_buf),
    .any_rstn_rr     (any_rstn_rr),
    .link_status     (link_status),
    .gen2_speed      (gen2_speed),
    .alive_led       (alive_led),
    .comp_led        (comp_led),
    .l0_led          (l0_led),
    .gen2_led        (gen2_led),
    .lane_active_led (lane_active_led),
    .link_word       (link_word)
  );

  mgmt_write_decode #(
    .NUM_SFP (NUM_SFP)
  ) u_write_decode (
    .clk_out_buf   (clk_out_buf),
    .any_rstn_rr   (any_rstn_rr),
    .mgmt_write    (mgmt_write),
    .mgmt_wdata    (mgmt_wdata),
    .cage_wr       (cage_wr),
    .rate_sel_in   (rate_sel_in),
    .tx_disable_in (tx_disable_in),
    .prwdn_in      (prwdn_in)
  );

  // one control block per sfp+ cage
  for (genvar i = 0; i < NUM_SFP; i++)
  begin : g_cage
    sfp_cage u_cage (
      .clk_out_buf   (clk_out_buf),
      .any_rstn_rr   (any_rstn_rr),
      .cage_wr       (cage_wr[i]),
      .rate_sel_in   (rate_sel_in[i]),
      .tx_disable_in (tx_disable_in[i]),
      .prwdn_in      (prwdn_in[i]),
      .tx_fault      (sfp_tx_fault[i]),
      .mod_abs       (sfp_mod_abs[i]),
      .rate_sel      (sfp_rate_sel[i]),
      .tx_disable    (sfp_tx_disable[i]),
      .lane_prwdn    (lane_prwdn[i]),
      .tx_fault_sync (tx_fault_sync[i]),
      .mod_abs_sync  (mod_abs_sync[i])
    );
  end

  status_word_assemble #(
    .NUM_SFP (NUM_SFP)
  ) u_status (
    .clk_out_buf   (clk_out_buf),
    .any_rstn_rr   (any_rstn_rr),
    .phy_reset_n   (phy_reset_n),
    .rate_sel      (sfp_rate_sel),
    .tx_disable    (sfp_tx_disable),
    .lane_prwdn    (lane_prwdn),
    .tx_fault_sync (tx_fault_sync),
    .mod_abs_sync  (mod_abs_sync),
    .link_word     (link_word),
    .mgmt_rdata_0  (mgmt_rdata_0),
    .mgmt_rdata_1  (mgmt_rdata_1)
  );

endmodule

`default_nettype wire

// ==== test/tb_sonic_board_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sonic_board_ctrl
  import sonic_board_pkg::*;
();

  localparam int NUM_SFP     = 2;
  localparam int ALIVE_CNT_W = 6;
  localparam int CLK_PERIOD  = 8;
  localparam int RST_CYC     = 5;
  localparam int IDLE_CYC    = 6;
  localparam int LINK_CYC    = 60;
  localparam int WR_CYC      = 60;
  localparam int PIN_CYC     = 48;
  localparam int DRAIN_CYC   = 6;
  localparam int TOTAL_CYC   = RST_CYC + IDLE_CYC + LINK_CYC + WR_CYC + PIN_CYC + DRAIN_CYC;
  localparam int ALIVE_RUN   = 2 ** (ALIVE_CNT_W - 1);

  logic clk_out_buf, pcie_rstn, local_rstn_ext, gen2_speed, mgmt_write;
  logic [LINK_W-1:0]  link_status;
  logic [NUM_SFP-1:0] sfp_tx_fault, sfp_mod_abs;
  logic [MGMT_W-1:0]  mgmt_wdata;
  logic phy_reset_n, alive_led, comp_led, l0_led, gen2_led;
  logic [LANE_W-1:0]  lane_active_led;
  logic [NUM_SFP-1:0] sfp_rate_sel, sfp_tx_disable, lane_prwdn;
  logic [MGMT_W-1:0]  mgmt_rdata_0, mgmt_rdata_1;

  int err_cnt = 0;
  int chk_cnt = 0;
  int cyc = 0;
  int d1, d2, d3;
  int alive_run = 0;
  int alive_runs = 0;
  logic alive_seen = 1'b0;
  logic alive_last = 1'b0;
  logic check_en = 1'b0;
  logic [31:0] rng = 32'd57657;
  logic [LANE_W+2:0] led_exp;

  // input history, slot = cycle mod 4
  logic [LINK_W-1:0]  hist_link [4];
  logic               hist_gen2 [4];
  logic               hist_wr   [4];
  logic [MGMT_W-1:0]  hist_wdata [4];
  logic [NUM_SFP-1:0] hist_txf  [4];
  logic [NUM_SFP-1:0] hist_mabs [4];
  logic [NUM_SFP-1:0] exp_rate = '0, exp_txdis = '0, exp_prwdn = '0;
  logic [NUM_SFP-1:0] prev_rate = '0, prev_txdis = '0, prev_prwdn = '0;

  sonic_board_ctrl #(.NUM_SFP(NUM_SFP), .ALIVE_CNT_W(ALIVE_CNT_W)) dut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // every fourth pick is compliance, every fourth L0
  function automatic logic [LINK_W-1:0] pick_link(input logic [31:0] r);
    case (r[1:0])
      2'd0:    return {r[11:8], 5'd3};
      2'd1:    return {r[11:8], 5'd15};
      default: return r[12:4];
    endcase
  endfunction

  function automatic logic [NUM_SFP-1:0] field_of(input logic [MGMT_W-1:0] w, input int lsb);
    logic [NUM_SFP-1:0] f;
    for (int i = 0; i < NUM_SFP; i++)
      f[i] = w[lsb + i];
    return f;
  endfunction

  // {comp, l0, gen2, lanes}
  function automatic logic [LANE_W+2:0] ref_leds(input logic [LINK_W-1:0] link, input logic g2);
    logic [LTSSM_W-1:0] ltssm;
    ltssm = link[LTSSM_W-1:0];
    return {ltssm == 5'd3, ltssm == 5'd15, g2, link[LINK_W-1 -: LANE_W]};
  endfunction

  function automatic logic [MGMT_W-1:0] ref_word0(input logic [NUM_SFP-1:0] rate, txdis,
    prwdn, txf, mabs, input logic phy);
    logic [MGMT_W-1:0] w;
    w    = '0;
    w[0] = phy;
    for (int i = 0; i < NUM_SFP; i++)
    begin
      w[1 + i]               = rate[i];
      w[1 + NUM_SFP + i]     = txdis[i];
      w[1 + 2 * NUM_SFP + i] = prwdn[i];
      w[1 + 3 * NUM_SFP + i] = txf[i];
      w[1 + 4 * NUM_SFP + i] = mabs[i];
    end
    return w;
  endfunction

  function automatic logic [MGMT_W-1:0] ref_word1(input logic [LINK_W-1:0] link);
    return {{(MGMT_W-LINK_W){1'b0}}, link};
  endfunction

  task automatic check_value(input string name, input logic [MGMT_W-1:0] exp_val,
    input logic [MGMT_W-1:0] act_val);
    chk_cnt++;
    assert (act_val === exp_val)
    else
    begin
      err_cnt++;
      $display("error %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
    end
  endtask

  initial
  begin
    clk_out_buf = 1'b0;
    forever #(CLK_PERIOD / 2) clk_out_buf = ~clk_out_buf;
  end

  // record the inputs, then compare against the delayed reference
  always @(negedge clk_out_buf)
  begin
    hist_link[cyc % 4]  = link_status;
    hist_gen2[cyc % 4]  = gen2_speed;
    hist_wr[cyc % 4]    = mgmt_write;
    hist_wdata[cyc % 4] = mgmt_wdata;
    hist_txf[cyc % 4]   = sfp_tx_fault;
    hist_mabs[cyc % 4]  = sfp_mod_abs;
    d1 = (cyc + 3) % 4;
    d2 = (cyc + 2) % 4;
    d3 = (cyc + 1) % 4;
    prev_rate  = exp_rate;
    prev_txdis = exp_txdis;
    prev_prwdn = exp_prwdn;
    if (hist_wr[d2] === 1'b1)  // cage loads two cycles after the write
    begin
      exp_rate  = field_of(hist_wdata[d2], 1);
      exp_txdis = field_of(hist_wdata[d2], 1 + NUM_SFP);
      exp_prwdn = field_of(hist_wdata[d2], 1 + 2 * NUM_SFP);
    end
    // phy reset follows the board reset pin, also while in reset
    check_value("phy_reset_n", local_rstn_ext, phy_reset_n);
    if (check_en)
    begin
      led_exp = ref_leds(hist_link[d1], hist_gen2[d1]);
      check_value("comp_led", led_exp[LANE_W+2], comp_led);
      check_value("l0_led", led_exp[LANE_W+1], l0_led);
      check_value("gen2_led", led_exp[LANE_W], gen2_led);
      check_value("lane_active_led", led_exp[LANE_W-1:0], lane_active_led);
      check_value("sfp_rate_sel", exp_rate, sfp_rate_sel);
      check_value("sfp_tx_disable", exp_txdis, sfp_tx_disable);
      check_value("lane_prwdn", exp_prwdn, lane_prwdn);
      check_value("mgmt_rdata_0", ref_word0(prev_rate, prev_txdis, prev_prwdn, hist_txf[d3],
        hist_mabs[d3], local_rstn_ext), mgmt_rdata_0);
      check_value("mgmt_rdata_1", ref_word1(hist_link[d2]), mgmt_rdata_1);
      // blinker runs, counted from its first change
      if (alive_seen && alive_led === alive_last)
        alive_run++;
      else if (alive_seen)
      begin
        check_value("alive_led run length", ALIVE_RUN, alive_run);
        alive_runs++;
        alive_run = 1;
      end
      else if (alive_led !== alive_last)
      begin
        alive_seen = 1'b1;
        alive_run  = 1;
      end
      alive_last = alive_led;
    end
    cyc++;
  end

  initial
  begin
    pcie_rstn = 1'b0;
    local_rstn_ext = 1'b0;
    gen2_speed = 1'b0;
    link_status = '0;
    sfp_tx_fault = '0;
    sfp_mod_abs = '0;
    mgmt_write = 1'b0;
    mgmt_wdata = '0;
    repeat (RST_CYC) @(posedge clk_out_buf);
    pcie_rstn      <= 1'b1;
    local_rstn_ext <= 1'b1;
    repeat (IDLE_CYC - 1) @(posedge clk_out_buf);
    @(negedge clk_out_buf);
    // idle state after reset
    check_value("alive_led", '0, alive_led);
    check_value("comp_led", '0, comp_led);
    check_value("l0_led", '0, l0_led);
    check_value("gen2_led", '0, gen2_led);
    check_value("lane_active_led", '0, lane_active_led);
    check_value("sfp_rate_sel", '0, sfp_rate_sel);
    check_value("sfp_tx_disable", '0, sfp_tx_disable);
    check_value("lane_prwdn", '0, lane_prwdn);
    check_value("mgmt_rdata_1", '0, mgmt_rdata_1);
    check_value("mgmt_rdata_0", {{(MGMT_W-1){1'b0}}, local_rstn_ext}, mgmt_rdata_0);
    @(posedge clk_out_buf);
    check_en = 1'b1;
    repeat (LINK_CYC)
    begin
      @(posedge clk_out_buf);
      rng = xorshift32(rng);
      link_status <= pick_link(rng);
      gen2_speed  <= rng[31];
    end
    repeat (WR_CYC)
    begin
      @(posedge clk_out_buf);
      rng = xorshift32(rng);
      mgmt_write <= rng[3];
      rng = xorshift32(rng);
      mgmt_wdata <= rng;
    end
    @(posedge clk_out_buf);
    mgmt_write <= 1'b0;
    for (int i = 0; i < PIN_CYC; i++)
    begin
      @(posedge clk_out_buf);
      if (i % 6 == 0)  // pins held for six cycles
      begin
        rng = xorshift32(rng);
        sfp_tx_fault <= rng[NUM_SFP-1:0];
        sfp_mod_abs  <= rng[8 +: NUM_SFP];
      end
    end
    repeat (DRAIN_CYC) @(negedge clk_out_buf);
    #1;
    assert (alive_runs >= 2)
    else
    begin
      err_cnt++;
      $display("alive_led did not complete two runs, blinker period was not checked");
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    #((TOTAL_CYC + 40) * CLK_PERIOD);
    $display("timeout, stimulus did not finish within %0d cycles", TOTAL_CYC + 40);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sonic_board_ctrl.f ====
common/sonic_board_pkg.sv
design/link_led.sv
sfp_ctrl/mgmt_write_decode.sv
sfp_ctrl/sfp_cage.sv
sfp_ctrl/status_word_assemble.sv
design/sonic_board_ctrl.sv
test/tb_sonic_board_ctrl.sv

// ==== Bender.yml ====
package:
  name: sonic_board_ctrl

sources:
  - common/sonic_board_pkg.sv
  - design/link_led.sv
  - sfp_ctrl/mgmt_write_decode.sv
  - sfp_ctrl/sfp_cage.sv
  - sfp_ctrl/status_word_assemble.sv
  - design/sonic_board_ctrl.sv
  - target: simulation
    files:
      - test/tb_sonic_board_ctrl.sv
